// ==== hdl/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data word width
`define EX_DATA_W 32

// register file address width
`define EX_REG_ADDR_W 5

// shift amount, low bits of operand_1
`define EX_SHAMT_W 5

// op code width
`define EX_OP_W 8

// result class select width
`define EX_SEL_W 3

`endif

// ==== hdl/ex_pkg.sv ====
`include "ex_macros.svh"

package ex_pkg;

    typedef logic [`EX_DATA_W-1:0]     word_t;
    // hi in the upper word
    typedef logic [2*`EX_DATA_W-1:0]   dword_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP   = 8'b0000_0000,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MOVZ  = 8'b0000_1010,
        OP_MOVN  = 8'b0000_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_SLL   = 8'b0111_1100,
        OP_MUL   = 8'b1010_1001,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001
    } alu_op_e;

    typedef enum logic [`EX_SEL_W-1:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101,
        SEL_JUMP  = 3'b110
    } alu_sel_e;

endpackage

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  ex_pkg::alu_op_e   alu_op_i,
    input  ex_pkg::alu_sel_e  alu_sel_i,
    input  ex_pkg::word_t     operand_1_i,
    input  ex_pkg::word_t     operand_2_i,
    input  ex_pkg::word_t     link_addr_i,
    input  ex_pkg::reg_addr_t reg_write_addr_i,
    input  logic              reg_write_en_i,
    output logic              valid_o,
    output ex_pkg::word_t     reg_write_data_o,
    output ex_pkg::reg_addr_t reg_write_addr_o,
    output logic              reg_write_en_o,
    output ex_pkg::word_t     hi_o,
    output ex_pkg::word_t     lo_o
);

    ex_pkg::word_t alu_result;
    logic          ov_trap;

    hilo_if hl ();

    int_alu u_int_alu (
        .alu_op_i     (alu_op_i),
        .operand_1_i  (operand_1_i),
        .operand_2_i  (operand_2_i),
        .alu_result_o (alu_result),
        .ov_trap_o    (ov_trap)
    );

    // works beside the alu on the same operands
    hilo_unit u_hilo_unit (
        .alu_op_i    (alu_op_i),
        .operand_1_i (operand_1_i),
        .operand_2_i (operand_2_i),
        .hl          (hl.producer)
    );

    ex_writeback u_ex_writeback (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .valid_i          (valid_i),
        .alu_sel_i        (alu_sel_i),
        .alu_result_i     (alu_result),
        .link_addr_i      (link_addr_i),
        .ov_trap_i        (ov_trap),
        .reg_write_addr_i (reg_write_addr_i),
        .reg_write_en_i   (reg_write_en_i),
        .hl               (hl.holder),
        .valid_o          (valid_o),
        .reg_write_data_o (reg_write_data_o),
        .reg_write_addr_o (reg_write_addr_o),
        .reg_write_en_o   (reg_write_en_o),
        .hi_o             (hi_o),
        .lo_o             (lo_o)
    );

endmodule

// ==== hdl/ex_writeback.sv ====
`timescale 1ns/1ps

module ex_writeback (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  ex_pkg::alu_sel_e  alu_sel_i,
    input  ex_pkg::word_t     alu_result_i,
    input  ex_pkg::word_t     link_addr_i,
    input  logic              ov_trap_i,
    input  ex_pkg::reg_addr_t reg_write_addr_i,
    input  logic              reg_write_en_i,
    hilo_if.holder            hl,
    output logic              valid_o,
    output ex_pkg::word_t     reg_write_data_o,
    output ex_pkg::reg_addr_t reg_write_addr_o,
    output logic              reg_write_en_o,
    output ex_pkg::word_t     hi_o,
    output ex_pkg::word_t     lo_o
);

    ex_pkg::word_t wdata;
    logic          we;

    always_comb begin
        case (alu_sel_i)
            ex_pkg::SEL_LOGIC,
            ex_pkg::SEL_SHIFT,
            ex_pkg::SEL_ARITH: wdata = alu_result_i;
            ex_pkg::SEL_MOVE:  wdata = hl.move_data;
            ex_pkg::SEL_MUL:   wdata = hl.mul_lo;
            ex_pkg::SEL_JUMP:  wdata = link_addr_i;
            default:           wdata = '0;
        endcase
    end

    assign we = reg_write_en_i && valid_i && !ov_trap_i;

    // ex/mem boundary and hi/lo, same edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o          <= 1'b0;
            reg_write_data_o <= '0;
            reg_write_addr_o <= '0;
            reg_write_en_o   <= 1'b0;
            hi_o             <= '0;
            lo_o             <= '0;
        end else begin
            valid_o          <= valid_i;
            reg_write_data_o <= wdata;
            reg_write_addr_o <= reg_write_addr_i;
            reg_write_en_o   <= we;
            if (valid_i && hl.hilo_we) begin
                hi_o <= hl.hi_next;
                lo_o <= hl.lo_next;
            end
        end
    end

    // feed current hi/lo back to the producer
    assign hl.hi_q = hi_o;
    assign hl.lo_q = lo_o;

endmodule

// ==== hdl/hilo_if.sv ====
`timescale 1ns/1ps

interface hilo_if;

    // current hi/lo from the holder
    ex_pkg::word_t hi_q;
    ex_pkg::word_t lo_q;

    // update request, counts only with valid_i
    logic          hilo_we;
    ex_pkg::word_t hi_next;
    ex_pkg::word_t lo_next;

    ex_pkg::word_t move_data;
    ex_pkg::word_t mul_lo;

    modport producer (
        input  hi_q, lo_q,
        output hilo_we, hi_next, lo_next, move_data, mul_lo
    );

    modport holder (
        output hi_q, lo_q,
        input  hilo_we, hi_next, lo_next, move_data, mul_lo
    );

endinterface

// ==== hdl/hilo_unit.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module hilo_unit (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::word_t   operand_1_i,
    input  ex_pkg::word_t   operand_2_i,
    hilo_if.producer        hl
);

    logic                          mul_signed;
    logic signed [`EX_DATA_W:0]    mul_a;
    logic signed [`EX_DATA_W:0]    mul_b;
    logic signed [2*`EX_DATA_W+1:0] prod_full;
    ex_pkg::dword_t                product;

    // MULTU is the only unsigned multiply
    assign mul_signed = (alu_op_i != ex_pkg::OP_MULTU);

    // one 33x33 signed multiplier covers both cases
    assign mul_a = {mul_signed & operand_1_i[`EX_DATA_W-1], operand_1_i};
    assign mul_b = {mul_signed & operand_2_i[`EX_DATA_W-1], operand_2_i};

    assign prod_full = mul_a * mul_b;
    assign product   = prod_full[2*`EX_DATA_W-1:0];

    assign hl.mul_lo = product[`EX_DATA_W-1:0];

    // next hi/lo
    always_comb begin
        hl.hilo_we = 1'b0;
        hl.hi_next = hl.hi_q;
        hl.lo_next = hl.lo_q;
        case (alu_op_i)
            ex_pkg::OP_MULT,
            ex_pkg::OP_MULTU: begin
                hl.hilo_we = 1'b1;
                hl.hi_next = product[2*`EX_DATA_W-1:`EX_DATA_W];
                hl.lo_next = product[`EX_DATA_W-1:0];
            end
            ex_pkg::OP_MTHI: begin
                hl.hilo_we = 1'b1;
                hl.hi_next = operand_1_i;
            end
            ex_pkg::OP_MTLO: begin
                hl.hilo_we = 1'b1;
                hl.lo_next = operand_1_i;
            end
            default: begin
                hl.hilo_we = 1'b0;
            end
        endcase
    end

    // move results
    always_comb begin
        case (alu_op_i)
            ex_pkg::OP_MFHI: hl.move_data = hl.hi_q;
            ex_pkg::OP_MFLO: hl.move_data = hl.lo_q;
            ex_pkg::OP_MOVZ,
            ex_pkg::OP_MOVN: hl.move_data = operand_1_i;
            default:         hl.move_data = '0;
        endcase
    end

endmodule

// ==== hdl/int_alu.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module int_alu (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::word_t   operand_1_i,
    input  ex_pkg::word_t   operand_2_i,
    output ex_pkg::word_t   alu_result_o,
    output logic            ov_trap_o
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   is_sub;
    ex_pkg::word_t          operand_2_mux;
    ex_pkg::word_t          sum;
    logic                   overflow;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [5:0]             clz_cnt;
    logic [5:0]             clo_cnt;

    // 32 when no bit is set, otherwise index of the top set bit from msb
    function automatic logic [5:0] lead_zeros(input ex_pkg::word_t w);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < `EX_DATA_W; i++) begin
            if (w[i]) begin
                n = 6'(`EX_DATA_W - 1 - i);
            end
        end
        return n;
    endfunction

    assign shamt = operand_1_i[`EX_SHAMT_W-1:0];

    // slt shares the subtractor
    assign is_sub = (alu_op_i == ex_pkg::OP_SUB) || (alu_op_i == ex_pkg::OP_SUBU) ||
                    (alu_op_i == ex_pkg::OP_SLT);

    assign operand_2_mux = is_sub ? (~operand_2_i) + 1'b1 : operand_2_i;
    assign sum           = operand_1_i + operand_2_mux;

    // sign of b flips on subtract even for the minimum word
    assign overflow = (operand_1_i[`EX_DATA_W-1] == (operand_2_i[`EX_DATA_W-1] ^ is_sub)) &&
                      (sum[`EX_DATA_W-1] != operand_1_i[`EX_DATA_W-1]);

    // mixed signs decide directly, same signs look at the difference
    assign lt_signed = (operand_1_i[`EX_DATA_W-1] && !operand_2_i[`EX_DATA_W-1]) ||
                       ((operand_1_i[`EX_DATA_W-1] == operand_2_i[`EX_DATA_W-1]) &&
                        sum[`EX_DATA_W-1]);
    assign lt_unsigned = operand_1_i < operand_2_i;

    assign clz_cnt = lead_zeros(operand_1_i);
    assign clo_cnt = lead_zeros(~operand_1_i);

    always_comb begin
        case (alu_op_i)
            ex_pkg::OP_OR:    alu_result_o = operand_1_i | operand_2_i;
            ex_pkg::OP_AND:   alu_result_o = operand_1_i & operand_2_i;
            ex_pkg::OP_NOR:   alu_result_o = ~(operand_1_i | operand_2_i);
            ex_pkg::OP_XOR:   alu_result_o = operand_1_i ^ operand_2_i;
            ex_pkg::OP_SLL:   alu_result_o = operand_2_i << shamt;
            ex_pkg::OP_SRL:   alu_result_o = operand_2_i >> shamt;
            ex_pkg::OP_SRA:   alu_result_o = ex_pkg::word_t'($signed(operand_2_i) >>> shamt);
            ex_pkg::OP_ADD,
            ex_pkg::OP_ADDU,
            ex_pkg::OP_ADDI,
            ex_pkg::OP_ADDIU,
            ex_pkg::OP_SUB,
            ex_pkg::OP_SUBU:  alu_result_o = sum;
            ex_pkg::OP_SLT:   alu_result_o = ex_pkg::word_t'(lt_signed);
            ex_pkg::OP_SLTU:  alu_result_o = ex_pkg::word_t'(lt_unsigned);
            ex_pkg::OP_CLZ:   alu_result_o = ex_pkg::word_t'(clz_cnt);
            ex_pkg::OP_CLO:   alu_result_o = ex_pkg::word_t'(clo_cnt);
            default:          alu_result_o = '0;
        endcase
    end

    // only the trapping adds and sub suppress the write
    assign ov_trap_o = overflow && ((alu_op_i == ex_pkg::OP_ADD) ||
                                    (alu_op_i == ex_pkg::OP_ADDI) ||
                                    (alu_op_i == ex_pkg::OP_SUB));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ex stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_ex_stage -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+hdl
+incdir+testbench
hdl/ex_pkg.sv
hdl/hilo_if.sv
hdl/int_alu.sv
hdl/hilo_unit.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
testbench/tb_ex_stage.sv

// ==== testbench/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected ex/mem write and next hi/lo for one accepted instruction
function automatic void ex_ref(
    input  ex_pkg::alu_op_e  op,
    input  ex_pkg::alu_sel_e sel,
    input  ex_pkg::word_t    a,
    input  ex_pkg::word_t    b,
    input  ex_pkg::word_t    link,
    input  logic             en,
    input  ex_pkg::word_t    hi,
    input  ex_pkg::word_t    lo,
    output ex_pkg::word_t    wdata,
    output logic             we,
    output ex_pkg::word_t    hi_n,
    output ex_pkg::word_t    lo_n
);
    logic [32:0]    wide;
    ex_pkg::dword_t sprod;
    ex_pkg::dword_t uprod;
    ex_pkg::word_t  alu_word;
    ex_pkg::word_t  move_word;
    logic           ovf;
    int             n;

    alu_word  = '0;
    move_word = '0;
    ovf       = 1'b0;
    n         = 0;
    hi_n      = hi;
    lo_n      = lo;
    sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    uprod = {32'b0, a} * {32'b0, b};
    case (op)
        ex_pkg::OP_OR:    alu_word = a | b;
        ex_pkg::OP_AND:   alu_word = a & b;
        ex_pkg::OP_NOR:   alu_word = ~(a | b);
        ex_pkg::OP_XOR:   alu_word = a ^ b;
        ex_pkg::OP_SLL:   alu_word = b << a[4:0];
        ex_pkg::OP_SRL:   alu_word = b >> a[4:0];
        ex_pkg::OP_SRA:   alu_word = ex_pkg::word_t'($signed(b) >>> a[4:0]);
        ex_pkg::OP_ADDU,
        ex_pkg::OP_ADDIU: alu_word = a + b;
        ex_pkg::OP_SUBU:  alu_word = a - b;
        ex_pkg::OP_ADD,
        ex_pkg::OP_ADDI: begin
            wide     = {a[31], a} + {b[31], b};
            alu_word = wide[31:0];
            // top two bits disagree on signed overflow
            ovf      = wide[32] != wide[31];
        end
        ex_pkg::OP_SUB: begin
            wide     = {a[31], a} - {b[31], b};
            alu_word = wide[31:0];
            ovf      = wide[32] != wide[31];
        end
        ex_pkg::OP_SLT:   alu_word = {31'b0, $signed(a) < $signed(b)};
        ex_pkg::OP_SLTU:  alu_word = {31'b0, a < b};
        ex_pkg::OP_CLZ: begin
            while (n < 32 && !a[31 - n]) begin
                n++;
            end
            alu_word = ex_pkg::word_t'(n);
        end
        ex_pkg::OP_CLO: begin
            while (n < 32 && a[31 - n]) begin
                n++;
            end
            alu_word = ex_pkg::word_t'(n);
        end
        ex_pkg::OP_MULT:  {hi_n, lo_n} = sprod;
        ex_pkg::OP_MULTU: {hi_n, lo_n} = uprod;
        ex_pkg::OP_MTHI:  hi_n = a;
        ex_pkg::OP_MTLO:  lo_n = a;
        ex_pkg::OP_MFHI:  move_word = hi;
        ex_pkg::OP_MFLO:  move_word = lo;
        ex_pkg::OP_MOVZ,
        ex_pkg::OP_MOVN:  move_word = a;
        default:          alu_word = '0;
    endcase
    case (sel)
        ex_pkg::SEL_LOGIC,
        ex_pkg::SEL_SHIFT,
        ex_pkg::SEL_ARITH: wdata = alu_word;
        ex_pkg::SEL_MOVE:  wdata = move_word;
        ex_pkg::SEL_MUL:   wdata = sprod[31:0];
        ex_pkg::SEL_JUMP:  wdata = link;
        default:           wdata = '0;
    endcase
    we = en && !ovf;
endfunction

`endif

// ==== testbench/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage;

    logic              clk;
    logic              rst_n_i;
    logic              valid_i;
    ex_pkg::alu_op_e   alu_op_i;
    ex_pkg::alu_sel_e  alu_sel_i;
    ex_pkg::word_t     operand_1_i;
    ex_pkg::word_t     operand_2_i;
    ex_pkg::word_t     link_addr_i;
    ex_pkg::reg_addr_t reg_write_addr_i;
    logic              reg_write_en_i;
    logic              valid_o;
    ex_pkg::word_t     reg_write_data_o;
    ex_pkg::reg_addr_t reg_write_addr_o;
    logic              reg_write_en_o;
    ex_pkg::word_t     hi_o;
    ex_pkg::word_t     lo_o;

    // hi/lo as the model tracks them
    ex_pkg::word_t     model_hi = '0;
    ex_pkg::word_t     model_lo = '0;
    int                n_issued = 0;
    int                n_checked = 0;
    integer            seed = 22;

    ex_pkg::alu_op_e op_table [26] = '{
        ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_NOR, ex_pkg::OP_XOR,
        ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA, ex_pkg::OP_ADD,
        ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU, ex_pkg::OP_SUB,
        ex_pkg::OP_SUBU, ex_pkg::OP_SLT, ex_pkg::OP_SLTU, ex_pkg::OP_CLZ,
        ex_pkg::OP_CLO, ex_pkg::OP_MUL, ex_pkg::OP_MULT, ex_pkg::OP_MULTU,
        ex_pkg::OP_MFHI, ex_pkg::OP_MFLO, ex_pkg::OP_MTHI, ex_pkg::OP_MTLO,
        ex_pkg::OP_MOVZ, ex_pkg::OP_MOVN
    };

    `include "ex_ref_model.svh"

    ex_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input ex_pkg::word_t got,
                              input ex_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input ex_pkg::reg_addr_t got,
                              input ex_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            report_failure();
        end
    endtask

    // result class the decoder would pick for an op
    function automatic ex_pkg::alu_sel_e sel_for_op(input ex_pkg::alu_op_e op);
        case (op)
            ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_NOR, ex_pkg::OP_XOR:
                return ex_pkg::SEL_LOGIC;
            ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA:
                return ex_pkg::SEL_SHIFT;
            ex_pkg::OP_MFHI, ex_pkg::OP_MFLO, ex_pkg::OP_MOVZ, ex_pkg::OP_MOVN:
                return ex_pkg::SEL_MOVE;
            ex_pkg::OP_MUL:
                return ex_pkg::SEL_MUL;
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MTHI, ex_pkg::OP_MTLO,
            ex_pkg::OP_NOP:
                return ex_pkg::SEL_NOP;
            default:
                return ex_pkg::SEL_ARITH;
        endcase
    endfunction

    task automatic issue(input ex_pkg::alu_op_e op, input ex_pkg::alu_sel_e sel,
                         input ex_pkg::word_t a, input ex_pkg::word_t b,
                         input ex_pkg::word_t link, input ex_pkg::reg_addr_t addr,
                         input logic en);
        @(posedge clk);
        #1;
        valid_i          = 1'b1;
        alu_op_i         = op;
        alu_sel_i        = sel;
        operand_1_i      = a;
        operand_2_i      = b;
        link_addr_i      = link;
        reg_write_addr_i = addr;
        reg_write_en_i   = en;
        n_issued++;
    endtask

    task automatic issue_op(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                            input ex_pkg::word_t b);
        issue(op, sel_for_op(op), a, b, '0, ex_pkg::reg_addr_t'(n_issued), 1'b1);
    endtask

    // bubble that would move hi if it were valid
    task automatic drive_idle();
        @(posedge clk);
        #1;
        valid_i        = 1'b0;
        alu_op_i       = ex_pkg::OP_MTHI;
        alu_sel_i      = ex_pkg::SEL_NOP;
        operand_1_i    = 32'hdead_beef;
        reg_write_en_i = 1'b1;
    endtask

    initial begin : stimulus
        int             waited;
        int             idx;
        ex_pkg::word_t  a;
        ex_pkg::word_t  b;

        valid_i          = 1'b0;
        alu_op_i         = ex_pkg::OP_NOP;
        alu_sel_i        = ex_pkg::SEL_NOP;
        operand_1_i      = '0;
        operand_2_i      = '0;
        link_addr_i      = '0;
        reg_write_addr_i = '0;
        reg_write_en_i   = 1'b0;
        rst_n_i          = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        issue_op(ex_pkg::OP_OR, 32'hf0f0_1234, 32'h0f0f_00ff);
        issue_op(ex_pkg::OP_AND, 32'hf0f0_1234, 32'h0f0f_00ff);
        issue_op(ex_pkg::OP_NOR, 32'hf0f0_1234, 32'h0f0f_00ff);
        issue_op(ex_pkg::OP_XOR, 32'hf0f0_1234, 32'h0f0f_00ff);
        issue_op(ex_pkg::OP_SLL, 32'd0, 32'h8000_0001);
        issue_op(ex_pkg::OP_SLL, 32'd31, 32'h0000_0001);
        issue_op(ex_pkg::OP_SRL, 32'd31, 32'h8000_0000);
        issue_op(ex_pkg::OP_SRA, 32'd4, 32'h8000_00f0);
        issue_op(ex_pkg::OP_SRA, 32'd31, 32'hffff_0000);
        issue_op(ex_pkg::OP_SRA, 32'd0, 32'h8765_4321);
        issue_op(ex_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001);
        issue_op(ex_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001);
        issue_op(ex_pkg::OP_SLT, 32'h0000_0001, 32'hffff_ffff);
        issue_op(ex_pkg::OP_SLTU, 32'h0000_0001, 32'hffff_ffff);
        issue_op(ex_pkg::OP_CLZ, 32'h0000_0000, '0);
        issue_op(ex_pkg::OP_CLZ, 32'hffff_ffff, '0);
        issue_op(ex_pkg::OP_CLZ, 32'h0000_8000, '0);
        issue_op(ex_pkg::OP_CLO, 32'h0000_0000, '0);
        issue_op(ex_pkg::OP_CLO, 32'hffff_ffff, '0);
        issue_op(ex_pkg::OP_CLO, 32'h8000_0000, '0);
        // signed overflow on the trapping forms only
        issue_op(ex_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        issue_op(ex_pkg::OP_ADDI, 32'h7fff_ffff, 32'h0000_0001);
        issue_op(ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        issue_op(ex_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
        issue_op(ex_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
        issue_op(ex_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
        // subtracting the minimum word
        issue_op(ex_pkg::OP_SUB, 32'h0000_0005, 32'h8000_0000);
        issue_op(ex_pkg::OP_SUB, 32'hffff_ffff, 32'h8000_0000);
        issue_op(ex_pkg::OP_MULT, 32'hffff_fffd, 32'h0000_0007);
        issue_op(ex_pkg::OP_MFHI, '0, '0);
        issue_op(ex_pkg::OP_MFLO, '0, '0);
        issue_op(ex_pkg::OP_MULTU, 32'hffff_fffe, 32'hffff_fffd);
        issue_op(ex_pkg::OP_MFHI, '0, '0);
        issue_op(ex_pkg::OP_MFLO, '0, '0);
        issue_op(ex_pkg::OP_MUL, 32'hffff_fffb, 32'h0000_3039);
        issue_op(ex_pkg::OP_MTHI, 32'h1234_5678, '0);
        issue_op(ex_pkg::OP_MTLO, 32'h9abc_def0, '0);
        drive_idle();
        drive_idle();
        issue_op(ex_pkg::OP_MFHI, '0, '0);
        issue_op(ex_pkg::OP_MFLO, '0, '0);
        issue_op(ex_pkg::OP_MOVZ, 32'hcafe_f00d, 32'h0000_0000);
        issue_op(ex_pkg::OP_MOVN, 32'h0bad_cafe, 32'h0000_0001);
        issue(ex_pkg::OP_NOP, ex_pkg::SEL_JUMP, '0, '0, 32'h0040_0108, 5'd31, 1'b1);

        for (int k = 0; k < 300; k++) begin
            if (($random(seed) & 7) == 0) begin
                drive_idle();
            end
            idx = ($random(seed) & 32'h7fff_ffff) % 27;
            a   = $random(seed);
            b   = $random(seed);
            if (idx == 26) begin
                issue(ex_pkg::OP_NOP, ex_pkg::SEL_JUMP, a, b, $random(seed),
                      ex_pkg::reg_addr_t'($random(seed)), 1'b1);
            end else begin
                issue(op_table[idx], sel_for_op(op_table[idx]), a, b, '0,
                      ex_pkg::reg_addr_t'($random(seed)), ($random(seed) & 3) != 0);
            end
        end
        drive_idle();

        waited = 0;
        while (n_checked < n_issued) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                $display("timed out waiting for the last results to come out");
                report_failure();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin : compare
        int                waited;
        logic              exp_valid;
        logic              exp_we;
        ex_pkg::reg_addr_t exp_addr;
        ex_pkg::word_t     exp_data;
        ex_pkg::word_t     next_hi;
        ex_pkg::word_t     next_lo;

        waited = 0;
        @(negedge clk);
        while (!rst_n_i) begin
            check_bit("valid_o", valid_o, 1'b0);
            check_bit("reg_write_en_o", reg_write_en_o, 1'b0);
            check_word("reg_write_data_o", reg_write_data_o, '0);
            check_addr("reg_write_addr_o", reg_write_addr_o, '0);
            check_word("hi_o", hi_o, '0);
            check_word("lo_o", lo_o, '0);
            waited++;
            if (waited > 20) begin
                $display("reset was never released");
                report_failure();
            end
            @(negedge clk);
        end
        forever begin
            // inputs are stable here, taken by the DUT at this edge
            @(posedge clk);
            exp_valid = valid_i;
            exp_addr  = reg_write_addr_i;
            ex_ref(alu_op_i, alu_sel_i, operand_1_i, operand_2_i, link_addr_i,
                   reg_write_en_i, model_hi, model_lo, exp_data, exp_we, next_hi, next_lo);
            @(negedge clk);
            check_bit("valid_o", valid_o, exp_valid);
            if (exp_valid) begin
                check_word("reg_write_data_o", reg_write_data_o, exp_data);
                check_addr("reg_write_addr_o", reg_write_addr_o, exp_addr);
                check_bit("reg_write_en_o", reg_write_en_o, exp_we);
                model_hi = next_hi;
                model_lo = next_lo;
                n_checked++;
            end else begin
                check_bit("reg_write_en_o", reg_write_en_o, 1'b0);
            end
            check_word("hi_o", hi_o, model_hi);
            check_word("lo_o", lo_o, model_lo);
        end
    end

endmodule
